// ==== logic/coh_macros.svh ====
`ifndef COH_MACROS_SVH
`define COH_MACROS_SVH

// Block geometry
`define DC_BLOCK_WORDS 2   // 32-bit words per block

// Direct-mapped array size
`define DC_SETS 8

// Address split, tag + index + word select + byte offset = 32
`define DC_INDEX_W 3
`define DC_TAG_W 26

`endif

// ==== logic/coh_pkg.sv ====
`default_nettype none

`include "coh_macros.svh"

package coh_pkg;

    // Per-line coherence state
    typedef enum logic [1:0] {
        INVALID   = 2'b00,
        SHARED    = 2'b01,
        EXCLUSIVE = 2'b10,
        MODIFIED  = 2'b11
    } mesi_t;

    // Driven by L2 to pace word transfers
    typedef enum logic [1:0] {
        L2_FREE   = 2'b00,
        L2_BUSY   = 2'b01,
        L2_ACCESS = 2'b10
    } l2_state_t;

    // One address word, read raw or split into fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [`DC_TAG_W-1:0]   tag;      // 31:6
            logic [`DC_INDEX_W-1:0] index;    // 5:3
            logic                   word_sel; // 2
            logic [1:0]             byte_off; // 1:0
        } f;
    } coh_addr_u;

endpackage

`default_nettype wire

// ==== logic/l1_dcache.sv ====
`default_nettype none

`include "coh_macros.svh"

module l1_dcache import coh_pkg::*; (
    input  logic                          CLK,
    input  logic                          rst,
    // Processor port
    input  logic                          ren,
    input  logic                          wen,
    input  logic [31:0]                   addr,
    input  logic [31:0]                   wdata,
    output logic [31:0]                   rdata,
    output logic                          busy,
    // Incoming snoop from the peer
    input  logic                          snoop_valid,
    input  logic [31:0]                   snoop_addr,
    input  logic                          snoop_inv,
    output logic                          snoop_done,
    output logic                          snoop_hit,
    output logic                          snoop_dirty,
    output logic [32*`DC_BLOCK_WORDS-1:0] snoop_data,
    // Link to the coherency unit
    output logic                          cu_req,
    output logic                          cu_write,
    output logic                          cu_upgrade,
    output logic [31:0]                   cu_addr,
    output logic                          cu_victim_dirty,
    output logic [31:0]                   cu_victim_addr,
    output logic [32*`DC_BLOCK_WORDS-1:0] cu_victim_data,
    input  logic                          cu_done,
    input  logic [32*`DC_BLOCK_WORDS-1:0] cu_fill_data,
    input  mesi_t                         state_transfer,
    input  logic                          cu_busy
);

    // Snoop FSM encoding
    localparam logic [1:0] SNP_IDLE = 2'd0;
    localparam logic [1:0] SNP_LOOK = 2'd1; // Lookup and line update
    localparam logic [1:0] SNP_ANS  = 2'd2; // snoop_done cycle

    logic [`DC_TAG_W-1:0]          tag_q   [`DC_SETS];
    logic [32*`DC_BLOCK_WORDS-1:0] data_q  [`DC_SETS];
    mesi_t                         state_q [`DC_SETS];

    coh_addr_u                     req_a;     // Processor address
    coh_addr_u                     snp_a;     // Snoop address
    coh_addr_u                     vic_a;     // Rebuilt victim address
    mesi_t                         line_st;
    mesi_t                         snp_st;
    logic                          tag_match;
    logic                          proc_req;
    logic                          rd_ok;
    logic                          wr_ok;
    logic                          wr_go;
    logic                          need_bus;
    logic                          snp_stall;
    logic                          snp_match;
    logic [1:0]                    snp_q;
    logic [32*`DC_BLOCK_WORDS-1:0] fill_blk;

    always_comb begin
        req_a.raw      = addr;
        snp_a.raw      = snoop_addr;
        // Victim keeps the index, takes the stored tag
        vic_a          = '0;
        vic_a.f.tag    = tag_q[req_a.f.index];
        vic_a.f.index  = req_a.f.index;
    end

    assign line_st   = state_q[req_a.f.index];
    assign tag_match = (line_st != INVALID) && (tag_q[req_a.f.index] == req_a.f.tag);

    assign proc_req  = ren || wen;
    assign rd_ok     = ren && !wen && tag_match;                       // Any valid state
    assign wr_ok     = wen && tag_match && ((line_st == EXCLUSIVE) || (line_st == MODIFIED));
    assign need_bus  = proc_req && !(rd_ok || wr_ok);                  // Miss or upgrade

    // Processor waits while a snoop rewrites the arrays
    assign snp_stall = (snp_q == SNP_LOOK);
    assign wr_go     = wr_ok && !snp_stall;

    assign rdata = data_q[req_a.f.index][{req_a.f.word_sel, 5'd0} +: 32];
    assign busy  = proc_req && !((rd_ok || wr_ok) && !snp_stall);

    // Held while the request stays, the arrays at this index are stable
    assign cu_req          = need_bus && !snp_stall;
    assign cu_write        = wen;
    assign cu_upgrade      = wen && tag_match && (line_st == SHARED);
    assign cu_addr         = addr;
    assign cu_victim_dirty = !tag_match && (line_st == MODIFIED);
    assign cu_victim_addr  = vic_a.raw;
    assign cu_victim_data  = data_q[req_a.f.index];

    // Block installed at cu_done
    always_comb begin
        fill_blk = cu_upgrade ? data_q[req_a.f.index] : cu_fill_data; // Upgrade keeps own data
        if (wen) begin
            fill_blk[{req_a.f.word_sel, 5'd0} +: 32] = wdata;          // Merge the store word
        end
    end

    always_ff @(posedge CLK) begin
        if (cu_done) begin
            tag_q[req_a.f.index]  <= req_a.f.tag;
            data_q[req_a.f.index] <= fill_blk;
        end else if (wr_go) begin
            data_q[req_a.f.index][{req_a.f.word_sel, 5'd0} +: 32] <= wdata;
        end
    end

    // Line states, snoop update is last so it wins on the same index
    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < `DC_SETS; i++) begin
                state_q[i] <= INVALID;
            end
        end else begin
            if (wr_go) begin
                state_q[req_a.f.index] <= MODIFIED;  // E->M, M stays M
            end
            if (cu_done) begin
                state_q[req_a.f.index] <= state_transfer;
            end
            if (snp_stall && snp_match) begin
                state_q[snp_a.f.index] <= snoop_inv ? INVALID : SHARED;
            end
        end
    end

    assign snp_st    = state_q[snp_a.f.index];
    assign snp_match = (snp_st != INVALID) && (tag_q[snp_a.f.index] == snp_a.f.tag);

    // Snoop responder
    always_ff @(posedge CLK) begin
        if (rst) begin
            snp_q       <= SNP_IDLE;
            snoop_hit   <= 1'b0;
            snoop_dirty <= 1'b0;
        end else begin
            case (snp_q)
                SNP_IDLE: begin
                    // Wait out any transaction in flight
                    if (snoop_valid && !cu_busy && !cu_req) begin
                        snp_q <= SNP_LOOK;
                    end
                end
                SNP_LOOK: begin
                    snoop_hit   <= snp_match;
                    snoop_dirty <= snp_match && (snp_st == MODIFIED); // Only M is dirty
                    snp_q       <= SNP_ANS;
                end
                default: snp_q <= SNP_IDLE; // SNP_ANS
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (snp_stall) begin
            snoop_data <= data_q[snp_a.f.index];
        end
    end

    assign snoop_done = (snp_q == SNP_ANS);

endmodule

`default_nettype wire

// ==== logic/coherency_unit.sv ====
`default_nettype none

`include "coh_macros.svh"

module coherency_unit import coh_pkg::*; (
    input  logic                          CLK,
    input  logic                          rst,
    // Link from the cache
    input  logic                          cu_req,
    input  logic                          cu_write,
    input  logic                          cu_upgrade,
    input  logic [31:0]                   cu_addr,
    input  logic                          cu_victim_dirty,
    input  logic [31:0]                   cu_victim_addr,
    input  logic [32*`DC_BLOCK_WORDS-1:0] cu_victim_data,
    output logic                          cu_done,
    output logic [32*`DC_BLOCK_WORDS-1:0] cu_fill_data,
    output mesi_t                         state_transfer,
    output logic                          cu_busy,
    // Peer request port
    output logic                          peer_req,
    output logic [31:0]                   peer_addr,
    output logic                          peer_excl,
    input  logic                          peer_done,
    input  logic                          peer_hit,
    input  logic                          peer_dirty,
    input  logic [32*`DC_BLOCK_WORDS-1:0] peer_data,
    // L2 port
    output logic                          l2_ren,
    output logic                          l2_wen,
    output logic [31:0]                   l2_addr,
    output logic [31:0]                   l2_store,
    input  logic [31:0]                   l2_load,
    input  l2_state_t                     l2_state
);

    localparam int CNT_W = $clog2(`DC_BLOCK_WORDS);

    // FSM encoding
    localparam logic [2:0] IDLE       = 3'd0;
    localparam logic [2:0] WB_VICTIM  = 3'd1; // Dirty victim to L2
    localparam logic [2:0] SNOOP_PEER = 3'd2;
    localparam logic [2:0] WB_PEER    = 3'd3; // Peer dirty block to L2
    localparam logic [2:0] FETCH_L2   = 3'd4;
    localparam logic [2:0] DONE       = 3'd5;

    logic [2:0]                    st_q;
    logic [CNT_W-1:0]              word_cnt;
    logic [32*`DC_BLOCK_WORDS-1:0] block_q;    // Victim first, then the fill
    coh_addr_u                     addr_q;     // Missed address
    coh_addr_u                     vic_q;      // Victim address
    logic                          write_q;
    logic                          upgrade_q;
    mesi_t                         mesi_q;
    coh_addr_u                     l2_a;
    coh_addr_u                     peer_a;
    logic                          l2_step;
    logic                          last_word;

    // Word moves when L2 grants it
    assign l2_step   = (l2_ren || l2_wen) && (l2_state == L2_ACCESS);
    assign last_word = (word_cnt == CNT_W'(`DC_BLOCK_WORDS - 1));

    always_comb begin
        // Word address, victim block during its writeback
        l2_a.raw        = (st_q == WB_VICTIM) ? vic_q.raw : addr_q.raw;
        l2_a.f.word_sel = word_cnt;
        l2_a.f.byte_off = 2'b00;
        // Peer sees the block base
        peer_a            = addr_q;
        peer_a.f.word_sel = 1'b0;
        peer_a.f.byte_off = 2'b00;
    end

    assign l2_ren   = (st_q == FETCH_L2);
    assign l2_wen   = (st_q == WB_VICTIM) || (st_q == WB_PEER);
    assign l2_addr  = l2_a.raw;
    assign l2_store = block_q[{word_cnt, 5'd0} +: 32];

    assign peer_req  = (st_q == SNOOP_PEER); // Held until peer_done
    assign peer_addr = peer_a.raw;
    assign peer_excl = write_q;              // Store wants the only copy

    assign cu_busy        = (st_q != IDLE);
    assign cu_done        = (st_q == DONE);
    assign cu_fill_data   = block_q;
    assign state_transfer = mesi_q;

    // Sequencer
    always_ff @(posedge CLK) begin
        if (rst) begin
            st_q     <= IDLE;
            word_cnt <= '0;
            mesi_q   <= INVALID;
        end else begin
            case (st_q)
                IDLE: begin
                    word_cnt <= '0;
                    if (cu_req) begin
                        // Upgrade has no victim
                        st_q <= (cu_victim_dirty && !cu_upgrade) ? WB_VICTIM : SNOOP_PEER;
                    end
                end
                WB_VICTIM: begin
                    if (l2_step) begin
                        word_cnt <= last_word ? '0 : word_cnt + 1'b1;
                        if (last_word) begin
                            st_q <= SNOOP_PEER;
                        end
                    end
                end
                SNOOP_PEER: begin
                    if (peer_done) begin
                        word_cnt <= '0;
                        if (upgrade_q) begin
                            mesi_q <= MODIFIED;  // S->M, no data moves
                            st_q   <= DONE;
                        end else if (peer_hit) begin
                            mesi_q <= write_q ? MODIFIED : SHARED;
                            st_q   <= peer_dirty ? WB_PEER : DONE;
                        end else begin
                            mesi_q <= write_q ? MODIFIED : EXCLUSIVE;
                            st_q   <= FETCH_L2;
                        end
                    end
                end
                WB_PEER, FETCH_L2: begin
                    if (l2_step) begin
                        word_cnt <= last_word ? '0 : word_cnt + 1'b1;
                        if (last_word) begin
                            st_q <= DONE;
                        end
                    end
                end
                default: st_q <= IDLE;  // DONE, cu_done pulse
            endcase
        end
    end

    // Request capture and block register
    always_ff @(posedge CLK) begin
        case (st_q)
            IDLE: begin
                if (cu_req) begin
                    addr_q.raw <= cu_addr;
                    vic_q.raw  <= cu_victim_addr;
                    write_q    <= cu_write;
                    upgrade_q  <= cu_upgrade;
                    block_q    <= cu_victim_data;
                end
            end
            SNOOP_PEER: begin
                if (peer_done && peer_hit && !upgrade_q) begin
                    block_q <= peer_data;  // Cache-to-cache transfer
                end
            end
            FETCH_L2: begin
                if (l2_step) begin
                    block_q[{word_cnt, 5'd0} +: 32] <= l2_load;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/coh_subsystem.sv ====
`default_nettype none

`include "coh_macros.svh"

module coh_subsystem import coh_pkg::*; (
    input  logic                          CLK,
    input  logic                          rst,
    // Processor port
    input  logic                          ren,
    input  logic                          wen,
    input  logic [31:0]                   addr,
    input  logic [31:0]                   wdata,
    output logic [31:0]                   rdata,
    output logic                          busy,
    // Peer request port
    output logic                          peer_req,
    output logic [31:0]                   peer_addr,
    output logic                          peer_excl,
    input  logic                          peer_done,
    input  logic                          peer_hit,
    input  logic                          peer_dirty,
    input  logic [32*`DC_BLOCK_WORDS-1:0] peer_data,
    // L2 port
    output logic                          l2_ren,
    output logic                          l2_wen,
    output logic [31:0]                   l2_addr,
    output logic [31:0]                   l2_store,
    input  logic [31:0]                   l2_load,
    input  l2_state_t                     l2_state,
    // Snoop port
    input  logic                          snoop_valid,
    input  logic [31:0]                   snoop_addr,
    input  logic                          snoop_inv,
    output logic                          snoop_done,
    output logic                          snoop_hit,
    output logic                          snoop_dirty,
    output logic [32*`DC_BLOCK_WORDS-1:0] snoop_data
);

    // Cache to coherency unit link
    logic                          cu_req;
    logic                          cu_write;
    logic                          cu_upgrade;
    logic [31:0]                   cu_addr;
    logic                          cu_victim_dirty;
    logic [31:0]                   cu_victim_addr;
    logic [32*`DC_BLOCK_WORDS-1:0] cu_victim_data;
    logic                          cu_done;
    logic [32*`DC_BLOCK_WORDS-1:0] cu_fill_data;
    mesi_t                         state_transfer;
    logic                          cu_busy;

    l1_dcache u_dcache (
        .CLK             (CLK),
        .rst             (rst),
        .ren             (ren),
        .wen             (wen),
        .addr            (addr),
        .wdata           (wdata),
        .rdata           (rdata),
        .busy            (busy),
        .snoop_valid     (snoop_valid),
        .snoop_addr      (snoop_addr),
        .snoop_inv       (snoop_inv),
        .snoop_done      (snoop_done),
        .snoop_hit       (snoop_hit),
        .snoop_dirty     (snoop_dirty),
        .snoop_data      (snoop_data),
        .cu_req          (cu_req),
        .cu_write        (cu_write),
        .cu_upgrade      (cu_upgrade),
        .cu_addr         (cu_addr),
        .cu_victim_dirty (cu_victim_dirty),
        .cu_victim_addr  (cu_victim_addr),
        .cu_victim_data  (cu_victim_data),
        .cu_done         (cu_done),
        .cu_fill_data    (cu_fill_data),
        .state_transfer  (state_transfer),
        .cu_busy         (cu_busy)
    );

    coherency_unit u_coh (
        .CLK             (CLK),
        .rst             (rst),
        .cu_req          (cu_req),
        .cu_write        (cu_write),
        .cu_upgrade      (cu_upgrade),
        .cu_addr         (cu_addr),
        .cu_victim_dirty (cu_victim_dirty),
        .cu_victim_addr  (cu_victim_addr),
        .cu_victim_data  (cu_victim_data),
        .cu_done         (cu_done),
        .cu_fill_data    (cu_fill_data),
        .state_transfer  (state_transfer),
        .cu_busy         (cu_busy),
        .peer_req        (peer_req),
        .peer_addr       (peer_addr),
        .peer_excl       (peer_excl),
        .peer_done       (peer_done),
        .peer_hit        (peer_hit),
        .peer_dirty      (peer_dirty),
        .peer_data       (peer_data),
        .l2_ren          (l2_ren),
        .l2_wen          (l2_wen),
        .l2_addr         (l2_addr),
        .l2_store        (l2_store),
        .l2_load         (l2_load),
        .l2_state        (l2_state)
    );

endmodule

`default_nettype wire

// ==== verification/tb_coh_subsystem.sv ====
`default_nettype none

module tb_coh_subsystem import coh_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int OP_READ      = 0;
    localparam int OP_WRITE     = 1;
    localparam int OP_SNOOP     = 2;
    localparam int OP_SNOOP_INV = 3;
    localparam int MAX_WAIT     = 200; // Cycles per wait

    typedef struct {
        int          op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        p_hit;       // Peer model answer
        logic        p_dirty;
        logic [63:0] p_data;
        logic [31:0] exp_rdata;
        int          exp_l2_rd;   // Words read from L2
        int          exp_l2_wr;   // Words written to L2
        int          exp_peer;    // Peer requests
        int          exp_excl;    // Those with peer_excl
        logic        exp_shit;
        logic        exp_sdirty;
        logic [63:0] exp_sdata;
    } row_t;

    logic        CLK;
    logic        rst;
    logic        ren;
    logic        wen;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        busy;
    logic        peer_req;
    logic [31:0] peer_addr;
    logic        peer_excl;
    logic        peer_done = 1'b0;
    logic        peer_hit;
    logic        peer_dirty;
    logic [63:0] peer_data;
    logic        l2_ren;
    logic        l2_wen;
    logic [31:0] l2_addr;
    logic [31:0] l2_store;
    logic [31:0] l2_load   = '0;
    l2_state_t   l2_state  = L2_FREE;
    logic        snoop_valid;
    logic [31:0] snoop_addr;
    logic        snoop_inv;
    logic        snoop_done;
    logic        snoop_hit;
    logic        snoop_dirty;
    logic [63:0] snoop_data;

    logic [31:0] l2_mem [logic [31:0]]; // Sparse L2 contents
    int          l2_wait;
    int          l2_rd_total = 0;       // Running traffic counts
    int          l2_wr_total = 0;
    int          peer_total  = 0;
    int          excl_total  = 0;
    row_t        rows [$];
    int          row_idx;

    coh_subsystem u_coh_subsystem (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Unwritten words come from a pattern over the whole address
    function automatic logic [31:0] l2_fill(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] l2_read(input logic [31:0] a);
        if (l2_mem.exists(a)) begin
            return l2_mem[a];
        end
        return l2_fill(a);
    endfunction

    // L2 model with BUSY for 1 to 3 cycles then one ACCESS cycle per word
    always @(posedge CLK) begin
        if (rst) begin
            l2_state <= L2_FREE;
            l2_wait  <= 0;
        end else if (l2_ren || l2_wen) begin
            case (l2_state)
                L2_ACCESS: begin
                    if (l2_wen) begin
                        l2_mem[l2_addr] = l2_store;
                        l2_wr_total++;
                    end else begin
                        l2_rd_total++;
                    end
                    l2_state <= L2_FREE;
                end
                L2_FREE: begin
                    l2_wait  <= int'($urandom % 3) + 1;
                    l2_state <= L2_BUSY;
                end
                default: begin
                    if (l2_wait <= 1) begin
                        l2_load  <= l2_read(l2_addr); // Valid in the ACCESS cycle
                        l2_state <= L2_ACCESS;
                    end else begin
                        l2_wait <= l2_wait - 1;
                    end
                end
            endcase
        end else begin
            l2_state <= L2_FREE;
        end
    end

    // Peer model answers each request with a one-cycle peer_done
    always @(posedge CLK) begin
        if (rst) begin
            peer_done <= 1'b0;
        end else if (peer_done) begin
            peer_done <= 1'b0;
        end else if (peer_req) begin
            check_val("peer_addr", 64'(peer_addr), 64'({addr[31:3], 3'b000})); // Block base
            peer_done <= 1'b1;
            peer_total++;
            if (peer_excl) excl_total++;
        end
    end

    task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t row %0d: %s is %h, expected %h", $time, row_idx, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out after %0d cycles waiting for %s in row %0d", MAX_WAIT, what, row_idx);
        $display("** FAIL **");
        $fatal(1, "Timeout");
    endtask

    task automatic add_row(input int op, input logic [31:0] a, input logic [31:0] wd,
                           input logic ph, input logic pd, input logic [63:0] pdata,
                           input logic [31:0] erd, input int l2r, input int l2w,
                           input int pr, input int ex, input logic sh, input logic sd,
                           input logic [63:0] sdata);
        row_t r;
        r = '{op, a, wd, ph, pd, pdata, erd, l2r, l2w, pr, ex, sh, sd, sdata};
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Cold read with peer miss fills from L2 to EXCLUSIVE
        add_row(OP_READ, 32'h1004, 0, 0, 0, 0, l2_fill(32'h1004), 2, 0, 1, 0, 0, 0, 0);
        add_row(OP_WRITE, 32'h1000, 32'h1111_aaaa, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0); // E to M
        add_row(OP_READ, 32'h1000, 0, 0, 0, 0, 32'h1111_aaaa, 0, 0, 0, 0, 0, 0, 0);
        add_row(OP_SNOOP, 32'h1000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1,
                {l2_fill(32'h1004), 32'h1111_aaaa});
        add_row(OP_SNOOP, 32'h1000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0,
                {l2_fill(32'h1004), 32'h1111_aaaa});                             // Now SHARED
        add_row(OP_WRITE, 32'h1004, 32'h2222_bbbb, 1, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0); // Upgrade
        add_row(OP_SNOOP_INV, 32'h1000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1,
                64'h2222_bbbb_1111_aaaa);
        // Clean peer supplies the invalidated line
        add_row(OP_READ, 32'h1000, 0, 1, 0, 64'h3333_cccc_4444_dddd, 32'h4444_dddd,
                0, 0, 1, 0, 0, 0, 0);
        add_row(OP_WRITE, 32'h1000, 32'h5555_eeee, 1, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0);
        // Dirty peer block is also written to L2
        add_row(OP_READ, 32'h200c, 0, 1, 1, 64'h6666_0001_7777_0002, 32'h6666_0001,
                0, 2, 1, 0, 0, 0, 0);
        // Conflict on index 0 evicts the MODIFIED line first
        add_row(OP_READ, 32'h3000, 0, 0, 0, 0, l2_fill(32'h3000), 2, 2, 1, 0, 0, 0, 0);
        add_row(OP_READ, 32'h1004, 0, 0, 0, 0, 32'h3333_cccc, 2, 0, 1, 0, 0, 0, 0);
        // Write miss merges the store word into the L2 block
        add_row(OP_WRITE, 32'h4010, 32'h8888_1234, 0, 0, 0, 0, 2, 0, 1, 1, 0, 0, 0);
        add_row(OP_SNOOP, 32'h4010, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1,
                {l2_fill(32'h4014), 32'h8888_1234});
        add_row(OP_SNOOP, 32'h5018, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0); // Empty line
    endtask

    task automatic check_idle();
        repeat (5) begin
            @(negedge CLK);
            check_val("idle busy", 64'(busy), 64'd0);
            check_val("idle peer_req", 64'(peer_req), 64'd0);
            check_val("idle l2_ren", 64'(l2_ren), 64'd0);
            check_val("idle l2_wen", 64'(l2_wen), 64'd0);
            check_val("idle snoop_done", 64'(snoop_done), 64'd0);
        end
    endtask

    task automatic run_row(input row_t r);
        int          n;
        int          rd0;
        int          wr0;
        int          pr0;
        int          ex0;
        logic [31:0] got;
        @(posedge CLK);
        rd0 = l2_rd_total;   // Bus idle here so counts are stable
        wr0 = l2_wr_total;
        pr0 = peer_total;
        ex0 = excl_total;
        n   = 0;
        peer_hit   <= r.p_hit;
        peer_dirty <= r.p_dirty;
        peer_data  <= r.p_data;
        if (r.op == OP_READ || r.op == OP_WRITE) begin
            ren   <= (r.op == OP_READ);
            wen   <= (r.op == OP_WRITE);
            addr  <= r.addr;
            wdata <= r.wdata;
            @(negedge CLK);
            while (busy) begin
                if (n == MAX_WAIT) timeout_fail("busy low");
                n++;
                @(negedge CLK);
            end
            got = rdata;                          // Stable until the next edge
            @(posedge CLK);
            ren <= 1'b0;
            wen <= 1'b0;
            if (r.op == OP_READ) check_val("rdata", 64'(got), 64'(r.exp_rdata));
        end else begin
            snoop_valid <= 1'b1;
            snoop_addr  <= r.addr;
            snoop_inv   <= (r.op == OP_SNOOP_INV);
            @(negedge CLK);
            while (!snoop_done) begin
                if (n == MAX_WAIT) timeout_fail("snoop_done");
                n++;
                @(negedge CLK);
            end
            check_val("snoop_hit", 64'(snoop_hit), 64'(r.exp_shit));
            check_val("snoop_dirty", 64'(snoop_dirty), 64'(r.exp_sdirty));
            if (r.exp_shit) check_val("snoop_data", snoop_data, r.exp_sdata);
            @(posedge CLK);
            snoop_valid <= 1'b0;
        end
        check_val("L2 reads", 64'(l2_rd_total - rd0), 64'(r.exp_l2_rd));
        check_val("L2 writes", 64'(l2_wr_total - wr0), 64'(r.exp_l2_wr));
        check_val("peer requests", 64'(peer_total - pr0), 64'(r.exp_peer));
        check_val("peer_excl requests", 64'(excl_total - ex0), 64'(r.exp_excl));
    endtask

    initial begin
        void'($urandom(32'h2b03));
        rst         = 1'b1;
        ren         = 1'b0;
        wen         = 1'b0;
        addr        = '0;
        wdata       = '0;
        peer_hit    = 1'b0;
        peer_dirty  = 1'b0;
        peer_data   = '0;
        snoop_valid = 1'b0;
        snoop_addr  = '0;
        snoop_inv   = 1'b0;
        row_idx     = -1;
        build_table();
        repeat (8) @(posedge CLK);
        rst <= 1'b0;
        check_idle();
        foreach (rows[i]) begin
            row_idx = i;
            run_row(rows[i]);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/coh_pkg.sv
logic/l1_dcache.sv
logic/coherency_unit.sv
logic/coh_subsystem.sv
verification/tb_coh_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the coherence subsystem testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench, log in sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -f files.f --top-module tb_coh_subsystem -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	@cat sim.log
	@! grep -q '\*\* FAIL \*\*' sim.log
	@grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log
